// ==== include/mipsBus_consts.svh ====
// Address map, memory depth and timer register layout shared by the RTL and the testbench
`ifndef MIPSBUS_CONSTS_SVH
`define MIPSBUS_CONSTS_SVH

// Data memory, 1024 words at the bottom of the map
`define DM_WORDS      1024
`define DM_BASE       32'h0000_0000
`define DM_LIMIT      32'h0000_0FFF

// Timer register blocks, three words each
`define TIMER0_BASE   32'h0000_7F00
`define TIMER1_BASE   32'h0000_7F10
`define TIMER_SPAN    32'd12

// Timer register word offsets
`define TMR_CTRL      2'd0
`define TMR_PRESET    2'd1
`define TMR_COUNT     2'd2

// CTRL register fields
`define CTRL_EN       0
`define CTRL_MODE     2:1
`define CTRL_IM       3

`define MODE_ONESHOT  2'd0
`define MODE_RELOAD   2'd1

// Bit positions in the 7:2 interrupt vector
`define HWINT_TIMER0  2
`define HWINT_TIMER1  3
`define HWINT_EXT     4

`endif

// ==== src/mipsBusPkg.sv ====
// Bus word types, request structs and timer state encoding, referenced by scoped name
package mipsBusPkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // All zero means a read
    typedef logic [3:0] byteEn_t;

    typedef logic [1:0] regSel_t;

    // Numbered like the CP0 cause field
    typedef logic [7:2] hwInt_t;

    // Processor side request, presented every cycle
    typedef struct packed {
        addr_t   addr;
        word_t   wdata;
        byteEn_t byteEn;
    } busReq_t;

    // Access to one timer register
    typedef struct packed {
        regSel_t regSel;
        word_t   wdata;
        logic    we;
    } devReq_t;

    typedef enum logic [1:0] {
        stIdle  = 2'd0,
        stLoad  = 2'd1,
        stCount = 2'd2,
        stIrq   = 2'd3
    } timerState_t;

endpackage

// ==== src/northBridge.sv ====
// First level address decode, routes processor accesses to data memory or the south bridge
`timescale 1ns/1ps
`include "mipsBus_consts.svh"

module northBridge (
    input  mipsBusPkg::busReq_t  req,
    output mipsBusPkg::word_t    rdata,
    output logic                 busError,
    output mipsBusPkg::addr_t    dmAddr,
    output mipsBusPkg::word_t    dmWdata,
    output mipsBusPkg::byteEn_t  dmByteEn,
    input  mipsBusPkg::word_t    dmRdata,
    output mipsBusPkg::busReq_t  sbReq,
    output logic                 sbWe,
    input  mipsBusPkg::word_t    sbRdata
);

    logic dmSel;
    logic timer0Hit;
    logic timer1Hit;
    logic sbSel;
    logic isWrite;
    logic fullWord;

    // Offset compares keep each window check to a single unsigned test
    assign dmSel     = (req.addr - `DM_BASE) < (`DM_LIMIT - `DM_BASE + 32'd1);
    assign timer0Hit = (req.addr - `TIMER0_BASE) < `TIMER_SPAN;
    assign timer1Hit = (req.addr - `TIMER1_BASE) < `TIMER_SPAN;
    assign sbSel     = timer0Hit | timer1Hit;

    assign isWrite  = |req.byteEn;
    assign fullWord = &req.byteEn;

    // Memory side, byte enables only reach a selected memory
    assign dmAddr   = req.addr;
    assign dmWdata  = req.wdata;
    assign dmByteEn = dmSel ? req.byteEn : '0;

    // Device side, registers accept full words only
    assign sbReq.addr   = req.addr;
    assign sbReq.wdata  = req.wdata;
    assign sbReq.byteEn = sbSel ? req.byteEn : '0;
    assign sbWe         = sbSel & fullWord;

    always_comb begin
        if (dmSel) begin
            rdata = dmRdata;
        end else if (sbSel) begin
            rdata = sbRdata;
        end else begin
            rdata = '0;
        end
    end

    // Unmapped access of any kind, or a partial word device write
    assign busError = (~dmSel & ~sbSel) | (sbSel & isWrite & ~fullWord);

endmodule

// ==== src/dataMem.sv ====
// Word organised data memory with byte enable writes and same cycle reads
`timescale 1ns/1ps
`include "mipsBus_consts.svh"

module dataMem (
    input  logic                 clk,
    input  logic                 reset,
    input  mipsBusPkg::addr_t    addr,
    input  mipsBusPkg::word_t    wdata,
    input  mipsBusPkg::byteEn_t  byteEn,
    output mipsBusPkg::word_t    rdata
);

    localparam int IdxW = $clog2(`DM_WORDS);

    mipsBusPkg::word_t mem [0:`DM_WORDS-1];
    logic [IdxW-1:0]   wordIdx;

    // Byte address to word index
    assign wordIdx = addr[IdxW+1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            // Cleared so that reads never return X
            for (int i = 0; i < `DM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (byteEn[b]) begin
                    mem[wordIdx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    assign rdata = mem[wordIdx];

endmodule

// ==== src/southBridge.sv ====
// Device level decode, splits accesses between the two timers and builds the interrupt vector
`timescale 1ns/1ps
`include "mipsBus_consts.svh"

module southBridge (
    input  mipsBusPkg::busReq_t  req,
    input  logic                 we,
    output mipsBusPkg::word_t    rdata,
    output mipsBusPkg::devReq_t  timer0Req,
    input  mipsBusPkg::word_t    timer0Rdata,
    input  logic                 timer0Irq,
    output mipsBusPkg::devReq_t  timer1Req,
    input  mipsBusPkg::word_t    timer1Rdata,
    input  logic                 timer1Irq,
    input  logic                 extInt,
    output mipsBusPkg::hwInt_t   hwInt
);

    logic                sel0;
    logic                sel1;
    mipsBusPkg::regSel_t regSel;

    assign sel0 = (req.addr - `TIMER0_BASE) < `TIMER_SPAN;
    assign sel1 = (req.addr - `TIMER1_BASE) < `TIMER_SPAN;

    // Both bases are 16 byte aligned, so the word offset is addr[3:2]
    assign regSel = req.addr[3:2];

    assign timer0Req.regSel = regSel;
    assign timer0Req.wdata  = req.wdata;
    assign timer0Req.we     = we & sel0;

    assign timer1Req.regSel = regSel;
    assign timer1Req.wdata  = req.wdata;
    assign timer1Req.we     = we & sel1;

    always_comb begin
        if (sel0) begin
            rdata = timer0Rdata;
        end else if (sel1) begin
            rdata = timer1Rdata;
        end else begin
            rdata = '0;
        end
    end

    // Interrupt vector, bits 7:5 unused
    always_comb begin
        hwInt                = '0;
        hwInt[`HWINT_TIMER0] = timer0Irq;
        hwInt[`HWINT_TIMER1] = timer1Irq;
        hwInt[`HWINT_EXT]    = extInt;
    end

endmodule

// ==== src/timer.sv ====
// Programmable countdown timer with one-shot and auto-reload modes and a maskable interrupt
`timescale 1ns/1ps
`include "mipsBus_consts.svh"

module timer (
    input  logic                 clk,
    input  logic                 reset,
    input  mipsBusPkg::devReq_t  req,
    output mipsBusPkg::word_t    rdata,
    output logic                 irq
);

    mipsBusPkg::word_t       ctrl;
    mipsBusPkg::word_t       preset;
    mipsBusPkg::word_t       count;
    mipsBusPkg::timerState_t state;
    logic                    ctrlWr;
    logic                    presetWr;
    logic                    reload;

    assign ctrlWr   = req.we && (req.regSel == `TMR_CTRL);
    assign presetWr = req.we && (req.regSel == `TMR_PRESET);
    // Mode values other than reload behave as one-shot
    assign reload   = ctrl[`CTRL_MODE] == `MODE_RELOAD;

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl   <= '0;
            preset <= '0;
            count  <= '0;
            state  <= mipsBusPkg::stIdle;
        end else begin
            if (ctrlWr) begin
                ctrl <= req.wdata;
            end
            if (presetWr) begin
                preset <= req.wdata;
            end

            if (ctrlWr && !req.wdata[`CTRL_EN]) begin
                // Disabling stops the timer from any state
                state <= mipsBusPkg::stIdle;
            end else begin
                case (state)
                    mipsBusPkg::stIdle: begin
                        if (ctrl[`CTRL_EN]) begin
                            state <= mipsBusPkg::stLoad;
                            count <= preset;
                        end
                    end
                    mipsBusPkg::stLoad,
                    mipsBusPkg::stCount: begin
                        // Count reaches zero on the same edge the irq state is entered
                        if (count <= 32'd1) begin
                            count <= '0;
                            state <= mipsBusPkg::stIrq;
                        end else begin
                            count <= count - 32'd1;
                            state <= mipsBusPkg::stCount;
                        end
                    end
                    mipsBusPkg::stIrq: begin
                        if (reload) begin
                            state <= mipsBusPkg::stLoad;
                            count <= preset;
                        end
                    end
                    default: state <= mipsBusPkg::stIdle;
                endcase
            end
        end
    end

    // COUNT is read only, offset 3 reads zero
    always_comb begin
        case (req.regSel)
            `TMR_CTRL:   rdata = ctrl;
            `TMR_PRESET: rdata = preset;
            `TMR_COUNT:  rdata = count;
            default:     rdata = '0;
        endcase
    end

    assign irq = (state == mipsBusPkg::stIrq) && ctrl[`CTRL_IM];

endmodule

// ==== src/mipsPeriph.sv ====
// Peripheral top level, wires the bridges, data memory and both timers below the processor bus
`timescale 1ns/1ps

module mipsPeriph (
    input  logic                 clk,
    input  logic                 reset,
    input  mipsBusPkg::busReq_t  req,
    output mipsBusPkg::word_t    rdata,
    output logic                 busError,
    input  logic                 interrupt,
    output mipsBusPkg::hwInt_t   hwInt
);

    // North bridge to data memory
    mipsBusPkg::addr_t   dmAddr;
    mipsBusPkg::word_t   dmWdata;
    mipsBusPkg::byteEn_t dmByteEn;
    mipsBusPkg::word_t   dmRdata;

    // North bridge to south bridge
    mipsBusPkg::busReq_t sbReq;
    logic                sbWe;
    mipsBusPkg::word_t   sbRdata;

    // South bridge to timers
    mipsBusPkg::devReq_t timer0Req;
    mipsBusPkg::word_t   timer0Rdata;
    logic                timer0Irq;
    mipsBusPkg::devReq_t timer1Req;
    mipsBusPkg::word_t   timer1Rdata;
    logic                timer1Irq;

    northBridge nbridge (
        .req(req), .rdata(rdata), .busError(busError),
        .dmAddr(dmAddr), .dmWdata(dmWdata), .dmByteEn(dmByteEn), .dmRdata(dmRdata),
        .sbReq(sbReq), .sbWe(sbWe), .sbRdata(sbRdata)
    );

    dataMem dmem (
        .clk(clk), .reset(reset),
        .addr(dmAddr), .wdata(dmWdata), .byteEn(dmByteEn), .rdata(dmRdata)
    );

    southBridge sbridge (
        .req(sbReq), .we(sbWe), .rdata(sbRdata),
        .timer0Req(timer0Req), .timer0Rdata(timer0Rdata), .timer0Irq(timer0Irq),
        .timer1Req(timer1Req), .timer1Rdata(timer1Rdata), .timer1Irq(timer1Irq),
        .extInt(interrupt), .hwInt(hwInt)
    );

    timer timer0 (
        .clk(clk), .reset(reset),
        .req(timer0Req), .rdata(timer0Rdata), .irq(timer0Irq)
    );

    timer timer1 (
        .clk(clk), .reset(reset),
        .req(timer1Req), .rdata(timer1Rdata), .irq(timer1Irq)
    );

endmodule

// ==== testbench/mipsPeriph_checker.sv ====
// Concurrent assertions on the peripheral top level, attached to it by the bind at the bottom
`timescale 1ns/1ps
`include "mipsBus_consts.svh"

module mipsPeriph_checker (
    input logic                clk,
    input logic                reset,
    input logic                interrupt,
    input logic                busError,
    input mipsBusPkg::busReq_t req,
    input mipsBusPkg::hwInt_t  hwInt,
    input mipsBusPkg::devReq_t timer0Req,
    input mipsBusPkg::devReq_t timer1Req
);

    logic mapped;
    logic fullAccess;
    logic t0CtrlWr;
    logic t1CtrlWr;
    logic t0OneShot;
    logic t1Reload;

    // Number of failed assertions
    int failCount = 0;

    assign mapped = (req.addr <= `DM_LIMIT)
        || (req.addr >= `TIMER0_BASE && req.addr < `TIMER0_BASE + `TIMER_SPAN)
        || (req.addr >= `TIMER1_BASE && req.addr < `TIMER1_BASE + `TIMER_SPAN);
    assign fullAccess = (req.byteEn == 4'h0) || (req.byteEn == 4'hF);

    assign t0CtrlWr = timer0Req.we && (timer0Req.regSel == `TMR_CTRL);
    assign t1CtrlWr = timer1Req.we && (timer1Req.regSel == `TMR_CTRL);

    // Timer modes as last written
    always_ff @(posedge clk) begin
        if (reset) begin
            t0OneShot <= 1'b1;
            t1Reload  <= 1'b0;
        end else begin
            if (t0CtrlWr) begin
                t0OneShot <= timer0Req.wdata[`CTRL_MODE] != `MODE_RELOAD;
            end
            if (t1CtrlWr) begin
                t1Reload <= timer1Req.wdata[`CTRL_MODE] == `MODE_RELOAD;
            end
        end
    end

    noErrorOnMapped: assert property (@(posedge clk) disable iff (reset)
        (mapped && fullAccess) |-> !busError)
        else begin
            failCount = failCount + 1;
            $error("bus error on a mapped full word access");
        end

    // One-shot irq only ends with a CTRL write
    oneShotHolds: assert property (@(posedge clk) disable iff (reset)
        (hwInt[`HWINT_TIMER0] && t0OneShot && !t0CtrlWr) |=> hwInt[`HWINT_TIMER0])
        else begin
            failCount = failCount + 1;
            $error("timer0 one-shot interrupt dropped without a CTRL write");
        end

    reloadPulse: assert property (@(posedge clk) disable iff (reset)
        (hwInt[`HWINT_TIMER1] && t1Reload) |=> !hwInt[`HWINT_TIMER1])
        else begin
            failCount = failCount + 1;
            $error("timer1 reload interrupt longer than one cycle");
        end

    unusedBitsZero: assert property (@(posedge clk) disable iff (reset)
        hwInt[7:5] == 3'b000)
        else begin
            failCount = failCount + 1;
            $error("hwInt bits 7 to 5 not zero");
        end

    extIntFollows: assert property (@(posedge clk) disable iff (reset)
        hwInt[`HWINT_EXT] == interrupt)
        else begin
            failCount = failCount + 1;
            $error("hwInt bit 4 differs from the external interrupt");
        end

endmodule

bind mipsPeriph mipsPeriph_checker periphChecks (
    .clk(clk), .reset(reset), .interrupt(interrupt), .busError(busError),
    .req(req), .hwInt(hwInt), .timer0Req(timer0Req), .timer1Req(timer1Req)
);

// ==== testbench/mipsPeriphTb.sv ====
// Testbench for the peripheral subsystem, drives the processor bus in place of the core
`timescale 1ns/1ps
`include "mipsBus_consts.svh"

module mipsPeriphTb;

    // About 800 cycles of tests plus margin
    localparam int WatchdogCycles = 4000;
    localparam int P0 = 5;
    localparam int P1 = 4;

    logic                clk = 1'b0;
    logic                reset;
    logic                interrupt;
    mipsBusPkg::busReq_t req;
    mipsBusPkg::word_t   rdata;
    logic                busError;
    mipsBusPkg::hwInt_t  hwInt;

    // Expected data memory contents
    mipsBusPkg::word_t memModel [0:`DM_WORDS-1];
    integer            seed;

    mipsPeriph mipsPeriph_inst (
        .clk(clk), .reset(reset), .req(req), .rdata(rdata),
        .busError(busError), .interrupt(interrupt), .hwInt(hwInt)
    );

    always #10 clk = ~clk;

    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    // Starts 2 ns after an edge and samples the response mid cycle
    task automatic access(input mipsBusPkg::addr_t addr, input mipsBusPkg::word_t wdata,
                          input mipsBusPkg::byteEn_t byteEn, output mipsBusPkg::word_t data,
                          output logic err);
        req.addr   = addr;
        req.wdata  = wdata;
        req.byteEn = byteEn;
        #8;
        data = rdata;
        err  = busError;
        @(posedge clk);
        #2;
        req = '0;
    endtask

    task automatic busWrite(input mipsBusPkg::addr_t addr, input mipsBusPkg::word_t wdata);
        mipsBusPkg::word_t data;
        logic              err;
        access(addr, wdata, 4'hF, data, err);
    endtask

    task automatic readExpect(input mipsBusPkg::addr_t addr, input mipsBusPkg::word_t exp);
        mipsBusPkg::word_t data;
        logic              err;
        access(addr, '0, '0, data, err);
        assert (data == exp) else
            stopRun($sformatf("Error at %0t ns: read 0x%h from 0x%h, expected 0x%h",
                              $time, data, addr, exp));
    endtask

    task automatic errorExpect(input mipsBusPkg::addr_t addr, input mipsBusPkg::word_t wdata,
                               input mipsBusPkg::byteEn_t byteEn);
        mipsBusPkg::word_t data;
        logic              err;
        access(addr, wdata, byteEn, data, err);
        assert (err) else
            stopRun($sformatf("Error at %0t ns: no bus error for 0x%h with byte enables %b",
                              $time, addr, byteEn));
        if (byteEn == '0) begin
            assert (data == '0) else
                stopRun($sformatf("Error at %0t ns: unmapped read of 0x%h gave 0x%h",
                                  $time, addr, data));
        end
    endtask

    task automatic mergeModel(input mipsBusPkg::addr_t addr, input mipsBusPkg::word_t wdata,
                              input mipsBusPkg::byteEn_t byteEn);
        for (int b = 0; b < 4; b++) begin
            if (byteEn[b]) begin
                memModel[addr[11:2]][8*b +: 8] = wdata[8*b +: 8];
            end
        end
    endtask

    // Counts cycles until an interrupt bit is seen high
    task automatic cyclesToRise(input int bitPos, input int limit, output int n);
        n = 0;
        do begin
            @(posedge clk);
            #2;
            n++;
        end while (!hwInt[bitPos] && n <= limit);
        if (!hwInt[bitPos]) begin
            stopRun($sformatf("Interrupt bit %0d did not rise within %0d cycles", bitPos, limit));
        end
    endtask

    task automatic checkExtInt(input logic level);
        interrupt = level;
        #8;
        assert (hwInt[`HWINT_EXT] == level) else
            stopRun($sformatf("Error at %0t ns: hwInt bit 4 is %b, expected %b",
                              $time, hwInt[`HWINT_EXT], level));
        @(posedge clk);
        #2;
    endtask

    initial begin
        mipsBusPkg::word_t   data;
        mipsBusPkg::word_t   wd;
        mipsBusPkg::word_t   prevCount;
        mipsBusPkg::addr_t   a;
        mipsBusPkg::byteEn_t be;
        logic [31:0]         r;
        logic                err;
        int                  n;

        seed      = 32'h84e3df59;
        reset     = 1'b1;
        interrupt = 1'b0;
        req       = '0;
        for (int i = 0; i < `DM_WORDS; i++) begin
            memModel[i] = '0;
        end
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;

        // State right after reset
        assert (hwInt == '0) else
            stopRun($sformatf("Error at %0t ns: hwInt is %b after reset", $time, hwInt));
        for (int t = 0; t < 2; t++) begin
            for (int o = 0; o < 3; o++) begin
                readExpect(`TIMER0_BASE + 16*t + 4*o, '0);
            end
        end
        checkExtInt(1'b1);
        checkExtInt(1'b0);

        // Random byte enable writes with an immediate read back
        for (int k = 0; k < 300; k++) begin
            r  = $random(seed);
            a  = {20'h0, r[11:2], 2'b00};
            be = r[15:12];
            wd = $random(seed);
            access(a, wd, be, data, err);
            mergeModel(a, wd, be);
            readExpect(a, memModel[a[11:2]]);
        end
        // Random read sweep
        for (int k = 0; k < 100; k++) begin
            r = $random(seed);
            a = {20'h0, r[11:2], 2'b00};
            readExpect(a, memModel[a[11:2]]);
        end

        errorExpect(32'h0000_1000, 32'h1234_5678, 4'h0);
        errorExpect(32'h0000_1000, 32'h1234_5678, 4'hF);
        errorExpect(`TIMER0_BASE + `TIMER_SPAN, '0, 4'h0);
        errorExpect(`TIMER1_BASE + `TIMER_SPAN, 32'h0000_0001, 4'hF);
        errorExpect(32'h8000_0000, 32'hFFFF_FFFF, 4'hF);
        // Partial word to PRESET must leave it alone
        errorExpect(`TIMER0_BASE + 4, 32'hDEAD_BEEF, 4'h3);
        readExpect(`TIMER0_BASE + 4, '0);

        // One-shot timer0 with EN and IM set
        busWrite(`TIMER0_BASE + 4, P0);
        busWrite(`TIMER0_BASE, 32'h9);
        n         = 0;
        prevCount = '0;
        while (!hwInt[`HWINT_TIMER0]) begin
            if (n > 4*P0) begin
                stopRun("Timer0 interrupt never rose after enabling the one-shot timer");
            end
            access(`TIMER0_BASE + 8, '0, '0, data, err);
            // COUNT is loaded one edge after the enable
            if (n >= 2) begin
                assert (data <= prevCount) else
                    stopRun($sformatf("Error at %0t ns: COUNT rose from %0d to %0d",
                                      $time, prevCount, data));
            end
            prevCount = data;
            n++;
        end
        assert (n == P0 + 1) else
            stopRun($sformatf("Error at %0t ns: timer0 irq after %0d cycles, expected %0d",
                              $time, n, P0 + 1));
        repeat (6) begin
            assert (hwInt[`HWINT_TIMER0]) else
                stopRun($sformatf("Error at %0t ns: one-shot irq dropped early", $time));
            @(posedge clk);
            #2;
        end
        busWrite(`TIMER0_BASE, '0);
        assert (!hwInt[`HWINT_TIMER0]) else
            stopRun($sformatf("Error at %0t ns: timer0 irq still high after disable", $time));

        // Auto-reload timer1 pulsing every P1+1 cycles
        busWrite(`TIMER1_BASE + 4, P1);
        busWrite(`TIMER1_BASE, 32'hB);
        for (int p = 0; p < 4; p++) begin
            cyclesToRise(`HWINT_TIMER1, 4*P1, n);
            assert (n == P1 + 1) else
                stopRun($sformatf("Error at %0t ns: timer1 pulse after %0d cycles, expected %0d",
                                  $time, n, P1 + 1));
        end
        // Interrupt masked while the timer keeps running
        busWrite(`TIMER1_BASE, 32'h3);
        repeat (3*(P1+1)) begin
            assert (!hwInt[`HWINT_TIMER1]) else
                stopRun($sformatf("Error at %0t ns: masked timer1 raised hwInt", $time));
            @(posedge clk);
            #2;
        end
        busWrite(`TIMER1_BASE, '0);

        if (mipsPeriph_inst.periphChecks.failCount == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            stopRun("A concurrent assertion in the checker failed");
        end
    end

    // Ends the run at the first checker failure
    initial begin
        wait (mipsPeriph_inst.periphChecks.failCount != 0);
        stopRun("A concurrent assertion in the checker failed");
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        stopRun("Watchdog expired before the tests finished");
    end

endmodule

// ==== verilog.f ====
+incdir+include
src/mipsBusPkg.sv
src/northBridge.sv
src/dataMem.sv
src/southBridge.sv
src/timer.sv
src/mipsPeriph.sv
testbench/mipsPeriph_checker.sv
testbench/mipsPeriphTb.sv

// ==== Makefile ====
# Verilator build and run of the peripheral testbench
TOP = mipsPeriphTb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
